//--- logic/boot_pkg.sv
// boot memory package: shared types, register map and ROM signature constants
package boot_pkg;

	typedef logic [15:0] addr_t;    // memory byte address
	typedef logic [7:0]  data_t;    // memory byte
	typedef logic [16:0] paddr_t;   // apb address, bit 16 picks register space

	// register space, bit 16 set
	localparam paddr_t reg_ctrl_addr   = 17'h1_0000;
	localparam paddr_t reg_status_addr = 17'h1_0001;

	// control register bits
	localparam int ctrl_load_bit  = 0;  // load active, host holds it
	localparam int ctrl_erase_bit = 1;  // erase request, self-clearing

	// status register bits
	localparam int stat_loaded_bit  = 0;
	localparam int stat_vdone_bit   = 1;
	localparam int stat_vok_bit     = 2;
	localparam int stat_erase_bit   = 3;
	localparam int stat_loading_bit = 4;

	// signature checked at addresses 0..3 after a load
	localparam int sig_len = 4;
	typedef data_t signature_t [sig_len];
	localparam signature_t rom_signature = '{8'hF3, 8'hC3, 8'h5A, 8'h02};

	// value the eraser writes into every byte
	localparam data_t fill_byte = 8'h00;

endpackage

//--- logic/host_port.sv
// host port: APB slave decoding memory-window writes and control/status registers
`timescale 1ns/10ps

module host_port (
	input  logic            CLOCK,
	input  logic            RESET,
	// apb slave
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  boot_pkg::paddr_t paddr,
	input  boot_pkg::data_t  pwdata,
	output boot_pkg::data_t  prdata,
	output logic            pready,
	output logic            pslverr,
	// status byte from the sequencer
	input  boot_pkg::data_t  status,
	// download write request
	output logic            host_wr,
	output boot_pkg::addr_t  host_addr,
	output boot_pkg::data_t  host_wdata,
	// control
	output logic            load_active,
	output logic            erase_request
);

	import boot_pkg::*;

	logic access;       // apb access phase
	logic mem_sel;      // memory window, bit 16 clear
	logic ctrl_wr;
	logic ctrl_rd;
	logic status_rd;

	assign access    = psel & penable;
	assign mem_sel   = ~paddr[16];
	assign ctrl_wr   = access & pwrite & (paddr == reg_ctrl_addr);
	assign ctrl_rd   = access & ~pwrite & (paddr == reg_ctrl_addr);
	assign status_rd = access & ~pwrite & (paddr == reg_status_addr);

	// no wait states
	assign pready = access;

	// memory window is write-only, reads there are errors
	assign pslverr = access & ~pwrite & mem_sel;

	// download write goes straight to the arbiter, lands on this edge
	assign host_wr    = access & pwrite & mem_sel;
	assign host_addr  = paddr[15:0];
	assign host_wdata = pwdata;

	// erase strobe, only during the one access cycle
	assign erase_request = ctrl_wr & pwdata[ctrl_erase_bit];

	always_comb begin
		prdata = '0;
		if (status_rd) begin
			prdata = status;
		end else if (ctrl_rd) begin
			prdata[ctrl_load_bit] = load_active;  // erase bit reads back 0
		end
	end

	// load-active bit held until the host clears it
	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			load_active <= 1'b0;
		end else if (ctrl_wr) begin
			load_active <= pwdata[ctrl_load_bit];
		end
	end

endmodule

//--- logic/memory_eraser.sv
// memory eraser: walks every address once and writes the fill byte
`timescale 1ns/10ps

module memory_eraser #(
	parameter int mem_depth = 65536
) (
	input  logic           CLOCK,
	input  logic           RESET,
	input  logic           erase_request,
	output logic           erase_busy,
	output logic           erase_wr,
	output boot_pkg::addr_t erase_addr,
	output boot_pkg::data_t erase_wdata
);

	import boot_pkg::*;

	localparam addr_t last_addr = addr_t'(mem_depth - 1);

	addr_t cnt;   // address being written this cycle

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			erase_busy <= 1'b0;
			cnt        <= '0;
		end else if (!erase_busy) begin
			if (erase_request) begin  // requests while busy are dropped
				erase_busy <= 1'b1;
				cnt        <= '0;
			end
		end else begin
			cnt <= cnt + 16'd1;
			if (cnt == last_addr) erase_busy <= 1'b0;  // mem_depth cycles total
		end
	end

	// one write per busy cycle
	assign erase_wr    = erase_busy;
	assign erase_addr  = cnt;
	assign erase_wdata = fill_byte;

endmodule

//--- logic/rom_verifier.sv
// ROM verifier: reads the four signature bytes and compares them with pipelined reads
`timescale 1ns/10ps

module rom_verifier (
	input  logic           CLOCK,
	input  logic           RESET,
	input  logic           verify_start,
	input  boot_pkg::data_t rd_data,      // ram output, one cycle after the read
	output logic           verify_busy,
	output logic           verify_rd,
	output boot_pkg::addr_t verify_addr,
	output logic           verify_done,
	output logic           verify_ok
);

	import boot_pkg::*;

	logic [2:0] rd_cnt;      // reads issued, 0..4
	logic       cmp_valid;   // rd_data holds a signature byte
	logic [1:0] cmp_idx;     // which byte is on rd_data
	logic [2:0] match_cnt;
	logic       hit;
	logic [2:0] match_next;

	assign verify_rd   = verify_busy & (rd_cnt != 3'd4);
	assign verify_addr = {14'b0, rd_cnt[1:0]};

	assign hit        = cmp_valid & (rd_data == rom_signature[cmp_idx]);
	assign match_next = match_cnt + {2'b0, hit};

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			verify_busy <= 1'b0;
			verify_done <= 1'b0;
			verify_ok   <= 1'b0;
			rd_cnt      <= '0;
			cmp_valid   <= 1'b0;
			cmp_idx     <= '0;
			match_cnt   <= '0;
		end else if (verify_start) begin
			verify_busy <= 1'b1;
			verify_done <= 1'b0;  // old result cleared on restart
			verify_ok   <= 1'b0;
			rd_cnt      <= '0;
			cmp_valid   <= 1'b0;
			match_cnt   <= '0;
		end else if (verify_busy) begin
			cmp_valid <= verify_rd;   // compare next cycle
			cmp_idx   <= rd_cnt[1:0];
			if (verify_rd) rd_cnt <= rd_cnt + 3'd1;
			if (cmp_valid) match_cnt <= match_next;
			// last byte compared, result out
			if (cmp_valid && cmp_idx == 2'(sig_len - 1)) begin
				verify_busy <= 1'b0;
				verify_done <= 1'b1;
				verify_ok   <= (match_next == 3'(sig_len));
			end
		end
	end

endmodule

//--- logic/memory_arbiter.sv
// memory arbiter: fixed-priority pick of the single RAM port among four requesters
`timescale 1ns/10ps

module memory_arbiter (
	// host download, highest priority
	input  logic           host_wr,
	input  boot_pkg::addr_t host_addr,
	input  boot_pkg::data_t host_wdata,
	// eraser
	input  logic           erase_wr,
	input  boot_pkg::addr_t erase_addr,
	input  boot_pkg::data_t erase_wdata,
	// verifier, read only
	input  logic           verify_rd,
	input  boot_pkg::addr_t verify_addr,
	// cpu, lowest priority
	input  logic           cpu_wr,
	input  logic           cpu_rd,
	input  boot_pkg::addr_t cpu_addr,
	input  boot_pkg::data_t cpu_wdata,
	input  logic           cpu_wait,
	// ram port
	output logic           ram_wr,
	output boot_pkg::addr_t ram_addr,
	output boot_pkg::data_t ram_wdata
);

	logic cpu_req;

	assign cpu_req = ~cpu_wait & (cpu_wr | cpu_rd);  // ignored while held

	always_comb begin
		ram_wr    = 1'b0;     // idle, nothing written
		ram_addr  = '0;
		ram_wdata = '0;
		if (host_wr) begin
			ram_wr    = 1'b1;
			ram_addr  = host_addr;
			ram_wdata = host_wdata;
		end else if (erase_wr) begin
			ram_wr    = 1'b1;
			ram_addr  = erase_addr;
			ram_wdata = erase_wdata;
		end else if (verify_rd) begin
			ram_addr = verify_addr;  // read only
		end else if (cpu_req) begin
			ram_wr    = cpu_wr;
			ram_addr  = cpu_addr;
			ram_wdata = cpu_wdata;
		end
	end

endmodule

//--- logic/boot_ram.sv
// boot RAM: synchronous byte memory with a registered read
`timescale 1ns/10ps

module boot_ram #(
	parameter int mem_depth = 65536
) (
	input  logic           CLOCK,
	input  logic           ram_wr,
	input  boot_pkg::addr_t ram_addr,
	input  boot_pkg::data_t ram_wdata,
	output boot_pkg::data_t rd_data
);

	import boot_pkg::*;

	localparam int aw = $clog2(mem_depth);

	data_t           mem [mem_depth];
	logic [aw-1:0]   idx;   // address wrapped to the depth

	assign idx = ram_addr[aw-1:0];

	always_ff @(posedge CLOCK) begin
		if (ram_wr) mem[idx] <= ram_wdata;
		rd_data <= mem[idx];  // old byte on a write cycle
	end

endmodule

//--- logic/boot_sequencer.sv
// boot sequencer: tracks load progress and drives CPU reset, CPU wait and status
`timescale 1ns/10ps

module boot_sequencer (
	input  logic           CLOCK,
	input  logic           RESET,
	input  logic           load_active,
	input  logic           erase_busy,
	input  logic           verify_busy,
	input  logic           verify_done,
	input  logic           verify_ok,
	output logic           verify_start,
	output logic           cpu_reset,
	output logic           cpu_wait,
	output boot_pkg::data_t status
);

	import boot_pkg::*;

	logic load_q;       // load_active one cycle back
	logic rom_loaded;
	logic load_fall;

	// end of a load, host cleared the load bit
	assign load_fall    = load_q & ~load_active;
	assign verify_start = load_fall;

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			load_q     <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			load_q <= load_active;
			if (load_active) begin
				rom_loaded <= 1'b0;  // image being replaced
			end else if (load_fall) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// cpu held in reset until a rom is in place and no erase runs
	assign cpu_reset = ~rom_loaded | erase_busy;

	// cpu stalled while memory belongs to host or verifier
	assign cpu_wait = ~rom_loaded | load_active | verify_busy;

	always_comb begin
		status                   = '0;
		status[stat_loaded_bit]  = rom_loaded;
		status[stat_vdone_bit]   = verify_done;
		status[stat_vok_bit]     = verify_ok;
		status[stat_erase_bit]   = erase_busy;
		status[stat_loading_bit] = load_active;
	end

endmodule

//--- logic/boot_memory_top.sv
// boot memory controller top: APB host port, eraser, verifier, arbiter, RAM and sequencer
`timescale 1ns/10ps

module boot_memory_top #(
	parameter int mem_depth = 65536
) (
	input  logic            CLOCK,
	input  logic            RESET,
	// apb slave
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  boot_pkg::paddr_t paddr,
	input  boot_pkg::data_t  pwdata,
	output boot_pkg::data_t  prdata,
	output logic            pready,
	output logic            pslverr,
	// cpu byte port
	input  boot_pkg::addr_t  cpu_addr,
	input  boot_pkg::data_t  cpu_wdata,
	input  logic            cpu_wr,
	input  logic            cpu_rd,
	output boot_pkg::data_t  cpu_rdata,
	output logic            cpu_reset,
	output logic            cpu_wait
);

	import boot_pkg::*;

	data_t status;
	logic  load_active, erase_request;
	logic  host_wr;
	addr_t host_addr;
	data_t host_wdata;
	logic  erase_busy, erase_wr;
	addr_t erase_addr;
	data_t erase_wdata;
	logic  verify_start, verify_busy, verify_rd, verify_done, verify_ok;
	addr_t verify_addr;
	logic  ram_wr;
	addr_t ram_addr;
	data_t ram_wdata;

	host_port u_host_port (
		.CLOCK, .RESET, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .status,
		.host_wr, .host_addr, .host_wdata, .load_active, .erase_request
	);

	memory_eraser #(.mem_depth(mem_depth)) u_eraser (
		.CLOCK, .RESET, .erase_request,
		.erase_busy, .erase_wr, .erase_addr, .erase_wdata
	);

	// ram read data shared by the verifier and the cpu
	rom_verifier u_verifier (
		.CLOCK, .RESET, .verify_start, .rd_data(cpu_rdata),
		.verify_busy, .verify_rd, .verify_addr, .verify_done, .verify_ok
	);

	memory_arbiter u_arbiter (
		.host_wr, .host_addr, .host_wdata,
		.erase_wr, .erase_addr, .erase_wdata,
		.verify_rd, .verify_addr,
		.cpu_wr, .cpu_rd, .cpu_addr, .cpu_wdata, .cpu_wait,
		.ram_wr, .ram_addr, .ram_wdata
	);

	boot_ram #(.mem_depth(mem_depth)) u_ram (
		.CLOCK, .ram_wr, .ram_addr, .ram_wdata, .rd_data(cpu_rdata)
	);

	boot_sequencer u_sequencer (
		.CLOCK, .RESET, .load_active, .erase_busy, .verify_busy,
		.verify_done, .verify_ok, .verify_start, .cpu_reset, .cpu_wait, .status
	);

endmodule

//--- dv/boot_memory_assert.sv
// boot memory assertions on APB ready, erase strobe width and CPU reset during erase
`timescale 1ns/10ps

module boot_memory_assert (
	input logic CLOCK,
	input logic RESET,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic erase_request,
	input logic erase_busy,
	input logic cpu_reset
);

	// every setup phase moves into an access phase with no wait states
	a_access_ready: assert property (@(posedge CLOCK) disable iff (RESET)
		(psel && !penable) |=> (psel && penable && pready))
		else $error("APB setup phase not followed by a ready access phase");

	// erase strobe is a single cycle
	a_erase_pulse: assert property (@(posedge CLOCK) disable iff (RESET)
		erase_request |=> !erase_request)
		else $error("erase_request held longer than one cycle");

	a_reset_in_erase: assert property (@(posedge CLOCK) disable iff (RESET)
		erase_busy |-> cpu_reset)  // cpu kept off the memory while it is wiped
		else $error("cpu_reset low while erase_busy is high");

endmodule

// host side with erase and cpu signals tied quiet
bind host_port boot_memory_assert u_host_assert (
	.CLOCK(CLOCK), .RESET(RESET), .psel(psel), .penable(penable), .pready(pready),
	.erase_request(erase_request), .erase_busy(1'b0), .cpu_reset(1'b1)
);

// sequencer side with apb inputs tied idle
bind boot_sequencer boot_memory_assert u_seq_assert (
	.CLOCK(CLOCK), .RESET(RESET), .psel(1'b0), .penable(1'b0), .pready(1'b1),
	.erase_request(1'b0), .erase_busy(erase_busy), .cpu_reset(cpu_reset)
);

//--- dv/tb_boot_memory.sv
// testbench for the boot memory controller with directed APB and CPU port tests
`timescale 1ns/10ps

module tb_boot_memory;

	import boot_pkg::*;

	localparam int mem_depth   = 256;
	localparam int cycle_limit = 2000;  // all tests need under 1000 cycles

	logic   CLOCK;
	logic   RESET;
	logic   psel;
	logic   penable;
	logic   pwrite;
	paddr_t paddr;
	data_t  pwdata;
	data_t  prdata;
	logic   pready;
	logic   pslverr;
	addr_t  cpu_addr;
	data_t  cpu_wdata;
	data_t  cpu_rdata;
	logic   cpu_wr;
	logic   cpu_rd;
	logic   cpu_reset;
	logic   cpu_wait;

	int    checks;
	int    errors;
	int    cycles;
	data_t image [$];   // bytes of the current rom image, from address 0

	boot_memory_top #(.mem_depth(mem_depth)) dut (.*);

	initial begin
		CLOCK = 1'b0;
		forever #10 CLOCK = ~CLOCK;  // 20 ns period
	end

	// run limit
	initial begin
		for (cycles = 0; cycles < cycle_limit; cycles++) begin
			@(posedge CLOCK);
		end
		$display("timeout, tests still running after %0d cycles", cycle_limit);
		$display("Checks failed");
		$finish;
	end

	task automatic check_byte(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic apb_write(input paddr_t addr, input data_t data);
		@(posedge CLOCK);
		#2;
		psel    = 1'b1;  // setup phase
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge CLOCK);
		#2;
		penable = 1'b1;  // access phase
		@(negedge CLOCK);
		check_bit("pready", pready, 1'b1);
		@(posedge CLOCK);  // write lands here
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input paddr_t addr, output data_t data, output logic err);
		@(posedge CLOCK);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge CLOCK);
		#2;
		penable = 1'b1;
		@(negedge CLOCK);  // outputs settled by mid access phase
		check_bit("pready", pready, 1'b1);
		data = prdata;
		err  = pslverr;
		@(posedge CLOCK);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_status(output data_t st);
		logic err;
		apb_read(reg_status_addr, st, err);
		check_bit("pslverr", err, 1'b0);
	endtask

	task automatic cpu_write(input addr_t addr, input data_t data);
		@(posedge CLOCK);
		#2;
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		@(posedge CLOCK);
		#2;
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(input addr_t addr, output data_t data);
		@(posedge CLOCK);
		#2;
		cpu_addr = addr;
		cpu_rd   = 1'b1;
		@(posedge CLOCK);  // read accepted and byte registered
		#2;
		cpu_rd = 1'b0;
		data   = cpu_rdata;
	endtask

	// image written between load bit up and load bit down
	task automatic load_image();
		apb_write(reg_ctrl_addr, data_t'(1 << ctrl_load_bit));
		for (int i = 0; i < image.size(); i++) begin
			apb_write(paddr_t'(i), image[i]);
		end
		apb_write(reg_ctrl_addr, 8'h00);
	endtask

	// poll status until the verifier reports
	task automatic wait_verify_done();
		data_t st;
		int    polls;
		st    = '0;
		polls = 0;
		while (!st[stat_vdone_bit] && polls < 20) begin
			read_status(st);
			polls++;
		end
		if (!st[stat_vdone_bit]) begin
			errors++;
			$display("verify_done never rose within %0d status reads", polls);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		$display("test %-14s finished, %0d errors", name, errors - err0);
	endtask

	task automatic after_reset();
		data_t st;
		int    err0;
		err0 = errors;
		read_status(st);
		check_byte("status", st, 8'h00);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		check_bit("cpu_wait", cpu_wait, 1'b1);
		report_test("reset_state", err0);
	endtask

	task automatic load_and_verify();
		data_t st;
		data_t rd;
		int    err0;
		err0 = errors;
		image.delete();
		for (int i = 0; i < sig_len; i++) begin
			image.push_back(rom_signature[2'(i)]);
		end
		for (int i = 0; i < 16; i++) begin
			image.push_back(data_t'($urandom()));  // body of the image
		end
		load_image();
		wait_verify_done();
		read_status(st);
		check_byte("status", st, 8'h07);  // rom_loaded, verify_done and verify_ok
		check_bit("cpu_reset", cpu_reset, 1'b0);
		check_bit("cpu_wait", cpu_wait, 1'b0);
		for (int i = 0; i < image.size(); i++) begin
			cpu_read(addr_t'(i), rd);
			check_byte($sformatf("cpu_rdata[%0h]", i), rd, image[i]);
		end
		report_test("load_verify", err0);
	endtask

	task automatic bad_signature();
		data_t st;
		int    err0;
		err0 = errors;
		image.delete();
		image.push_back(~rom_signature[0]);  // first byte wrong
		for (int i = 1; i < sig_len; i++) begin
			image.push_back(rom_signature[2'(i)]);
		end
		load_image();
		wait_verify_done();
		read_status(st);
		check_byte("status", st, 8'h03);  // loaded and done but no match
		check_bit("cpu_reset", cpu_reset, 1'b0);
		check_bit("cpu_wait", cpu_wait, 1'b0);
		report_test("bad_signature", err0);
	endtask

	task automatic cpu_write_read();
		data_t wd;
		data_t rd;
		int    err0;
		err0 = errors;
		wd   = data_t'($urandom());
		cpu_write(16'h0080, wd);
		cpu_read(16'h0080, rd);
		check_byte("cpu_rdata[80]", rd, wd);
		report_test("cpu_write_read", err0);
	endtask

	task automatic erase_all();
		data_t rd;
		int    held;
		int    err0;
		err0 = errors;
		apb_write(reg_ctrl_addr, data_t'(1 << ctrl_erase_bit));
		held = 0;
		@(negedge CLOCK);
		while (cpu_reset && held < 2 * mem_depth) begin  // bounded if stuck
			held++;
			@(negedge CLOCK);
		end
		check_count("cpu_reset cycles", held, mem_depth);
		for (int i = 0; i < mem_depth; i++) begin
			cpu_read(addr_t'(i), rd);
			check_byte($sformatf("cpu_rdata[%0h]", i), rd, fill_byte);
		end
		report_test("erase", err0);
	endtask

	task automatic window_read();
		data_t rd;
		logic  err;
		int    err0;
		err0 = errors;
		apb_read(17'h0_0010, rd, err);  // write-only memory window
		check_bit("pslverr", err, 1'b1);
		report_test("window_read", err0);
	endtask

	initial begin
		void'($urandom(80));
		RESET     = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_wr    = 1'b0;
		cpu_rd    = 1'b0;
		checks    = 0;
		errors    = 0;
		repeat (10) @(posedge CLOCK);
		#2;
		RESET = 1'b0;
		after_reset();
		load_and_verify();
		bad_signature();
		cpu_write_read();
		erase_all();
		window_read();
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
logic/boot_pkg.sv
logic/host_port.sv
logic/memory_eraser.sv
logic/rom_verifier.sv
logic/memory_arbiter.sv
logic/boot_ram.sv
logic/boot_sequencer.sv
logic/boot_memory_top.sv
dv/boot_memory_assert.sv
dv/tb_boot_memory.sv

//--- Makefile
TOP := tb_boot_memory
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard logic/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || echo "Checks failed" >> sim.log
	cat sim.log
	! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log
